//--- rtl/issue_pkg.sv
package issue_pkg;

  ////////////////////////////////////////////////////////////
  // widths and depth
  ////////////////////////////////////////////////////////////

  localparam int inst_width    = 32;
  localparam int addr_width    = 32;
  localparam int id_width      = 6;   // instruction tag.
  localparam int reg_bits      = 5;
  localparam int opcode_bits   = 6;

  localparam int iq_depth      = 8;
  localparam int iq_index_bits = 3;
  localparam int free_bits     = 4;   // holds 0 to iq_depth.

  ////////////////////////////////////////////////////////////
  // instruction fields
  ////////////////////////////////////////////////////////////

  localparam int opcode_lsb = 26;  // top six bits.
  localparam int rs_lsb     = 21;
  localparam int rt_lsb     = 16;  // dest for immediate and load forms.
  localparam int rd_lsb     = 11;

  // opcode bits 5:4 select the group.
  localparam logic [1:0] grp_reg_alu = 2'b00;
  localparam logic [1:0] grp_imm_alu = 2'b01;
  localparam logic [1:0] grp_memory  = 2'b10;
  localparam logic [1:0] grp_branch  = 2'b11;

  typedef enum logic [opcode_bits-1:0] {
    op_nop   = 6'd0,
    op_add   = 6'd1,
    op_sub   = 6'd2,
    op_cmp   = 6'd3,
    op_test  = 6'd4,
    op_addi  = 6'd16,
    op_subi  = 6'd17,
    op_cmpi  = 6'd18,
    op_testi = 6'd19,
    op_lw    = 6'd32,
    op_sw    = 6'd33,
    op_jmp   = 6'd48,
    op_je    = 6'd49,
    op_jo    = 6'd50
  } opcode_e;

  // execution pipe needed by an instruction.
  typedef enum logic [1:0] {
    pipe_any    = 2'd0,  // plain alu on either lane.
    pipe_branch = 2'd1,
    pipe_memory = 2'd2
  } pipe_e;

endpackage

//--- rtl/issue_queue.sv
`timescale 1ns/100ps

module issue_queue import issue_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,

  input  logic                  push0,
  input  logic                  push1,
  input  logic [inst_width-1:0] instruction0,
  input  logic [inst_width-1:0] instruction1,
  input  logic [addr_width-1:0] pc0,
  input  logic [addr_width-1:0] pc1,
  input  logic [id_width-1:0]   id0,
  input  logic [id_width-1:0]   id1,

  input  logic                     pop0,
  input  logic                     pop1,
  input  logic [iq_index_bits-1:0] pop_key0,
  input  logic [iq_index_bits-1:0] pop_key1,

  output logic [inst_width-1:0] entry_instruction [iq_depth],
  output logic [addr_width-1:0] entry_pc          [iq_depth],
  output logic [id_width-1:0]   entry_id          [iq_depth],
  output logic [iq_depth-1:0]   entry_valid,
  output logic [free_bits-1:0]  free
);

  logic [inst_width-1:0] next_instruction [iq_depth];
  logic [addr_width-1:0] next_pc          [iq_depth];
  logic [id_width-1:0]   next_id          [iq_depth];
  logic [iq_depth-1:0]   next_valid;
  logic [iq_depth-1:0]   keep;
  logic [free_bits-1:0]  count;
  logic [free_bits-1:0]  next_count;

  always_comb begin
    for (int k = 0; k < iq_depth; k++) begin
      keep[k] = entry_valid[k] &&
                !(pop0 && (pop_key0 == iq_index_bits'(k))) &&
                !(pop1 && (pop_key1 == iq_index_bits'(k)));
    end
  end

  ////////////////////////////////////////////////////////////
  // compaction, then append
  ////////////////////////////////////////////////////////////

  always_comb begin
    next_instruction = entry_instruction;
    next_pc          = entry_pc;
    next_id          = entry_id;
    next_valid       = '0;
    next_count       = '0;

    // survivors slide down, oldest stays at slot 0.
    for (int k = 0; k < iq_depth; k++) begin
      if (keep[k]) begin
        next_instruction[next_count[iq_index_bits-1:0]] = entry_instruction[k];
        next_pc[next_count[iq_index_bits-1:0]]          = entry_pc[k];
        next_id[next_count[iq_index_bits-1:0]]          = entry_id[k];
        next_valid[next_count[iq_index_bits-1:0]]       = 1'b1;
        next_count = next_count + 1'b1;
      end
    end

    if (push0) begin
      next_instruction[next_count[iq_index_bits-1:0]] = instruction0;
      next_pc[next_count[iq_index_bits-1:0]]          = pc0;
      next_id[next_count[iq_index_bits-1:0]]          = id0;
      next_valid[next_count[iq_index_bits-1:0]]       = 1'b1;
      next_count = next_count + 1'b1;
    end
    if (push1) begin  // younger of the pair.
      next_instruction[next_count[iq_index_bits-1:0]] = instruction1;
      next_pc[next_count[iq_index_bits-1:0]]          = pc1;
      next_id[next_count[iq_index_bits-1:0]]          = id1;
      next_valid[next_count[iq_index_bits-1:0]]       = 1'b1;
      next_count = next_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      entry_valid <= '0;
      count       <= '0;
    end else begin
      entry_valid <= next_valid;
      count       <= next_count;
    end
  end

  always_ff @(posedge clk) begin
    entry_instruction <= next_instruction;
    entry_pc          <= next_pc;
    entry_id          <= next_id;
  end

  assign free = free_bits'(iq_depth) - count;

endmodule

//--- rtl/reg_decode.sv
`timescale 1ns/100ps

module reg_decode import issue_pkg::*; (
  input  logic [inst_width-1:0] instruction,
  output logic [reg_bits-1:0]   src0,
  output logic [reg_bits-1:0]   src1,
  output logic [reg_bits-1:0]   dest,
  output logic                  src0_valid,
  output logic                  src1_valid,
  output logic                  dest_valid,
  output pipe_e                 pipe
);

  opcode_e opcode;

  assign opcode = opcode_e'(instruction[opcode_lsb +: opcode_bits]);

  always_comb begin
    src0       = instruction[rs_lsb +: reg_bits];
    src1       = instruction[rt_lsb +: reg_bits];
    dest       = instruction[rt_lsb +: reg_bits];
    src0_valid = 1'b0;
    src1_valid = 1'b0;
    dest_valid = 1'b0;
    pipe       = pipe_any;

    case (opcode[opcode_bits-1 -: 2])
      grp_reg_alu: begin
        dest = instruction[rd_lsb +: reg_bits];
        if (opcode != op_nop) begin
          src0_valid = 1'b1;
          src1_valid = 1'b1;
          dest_valid = 1'b1;
        end
        if (opcode == op_cmp || opcode == op_test) pipe = pipe_branch;  // flag writers.
      end
      grp_imm_alu: begin
        src0_valid = 1'b1;
        dest_valid = 1'b1;
        if (opcode == op_cmpi || opcode == op_testi) pipe = pipe_branch;
      end
      grp_memory: begin
        src0_valid = (opcode == op_lw) || (opcode == op_sw);
        src1_valid = (opcode == op_sw);  // store data.
        dest_valid = (opcode == op_lw);
        pipe       = pipe_memory;
      end
      grp_branch: pipe = pipe_branch;  // no registers.
    endcase
  end

endmodule

//--- rtl/order_hazard.sv
`timescale 1ns/100ps

module order_hazard import issue_pkg::*; (
  input  opcode_e                  opcode     [iq_depth],
  input  pipe_e                    pipe       [iq_depth],
  input  logic [reg_bits-1:0]      src0       [iq_depth],
  input  logic [reg_bits-1:0]      src1       [iq_depth],
  input  logic [reg_bits-1:0]      dest       [iq_depth],
  input  logic [iq_depth-1:0]      src0_valid,
  input  logic [iq_depth-1:0]      src1_valid,
  input  logic [iq_depth-1:0]      dest_valid,
  input  logic [iq_depth-1:0]      entry_valid,
  input  logic                     pop0,
  input  logic [iq_index_bits-1:0] pop_key0,
  output logic [iq_depth-1:0]      ready
);

  logic [iq_depth-1:0] is_branch;
  logic [iq_depth-1:0] is_compare;
  logic [iq_depth-1:0] is_memory;
  logic [iq_depth-1:0] blocked [iq_depth];  // blocked[i][j] set when older entry j holds back i.

  for (genvar i = 0; i < iq_depth; i++) begin : g_class
    assign is_branch[i]  = (opcode[i][opcode_bits-1 -: 2] == grp_branch);
    assign is_compare[i] = (opcode[i] == op_cmp)  || (opcode[i] == op_test) ||
                           (opcode[i] == op_cmpi) || (opcode[i] == op_testi);
    assign is_memory[i]  = (pipe[i] == pipe_memory);
  end

  ////////////////////////////////////////////////////////////
  // pairwise check against every older entry
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < iq_depth; i++) begin : g_young
    for (genvar j = 0; j < iq_depth; j++) begin : g_old
      if (j >= i) begin : g_none
        assign blocked[i][j] = 1'b0;
      end else begin : g_pair
        logic raw, war, waw, j_picked;

        assign raw = dest_valid[j] &&
                     ((src0_valid[i] && (src0[i] == dest[j])) ||
                      (src1_valid[i] && (src1[i] == dest[j])));
        assign war = dest_valid[i] &&
                     ((src0_valid[j] && (src0[j] == dest[i])) ||
                      (src1_valid[j] && (src1[j] == dest[i])));
        assign waw = dest_valid[i] && dest_valid[j] && (dest[i] == dest[j]);
        assign j_picked = pop0 && (pop_key0 == iq_index_bits'(j));

        // j leaving on pick 0 lifts only the ordering-only hazards.
        assign blocked[i][j] = entry_valid[j] &&
                               (raw ||
                                (!j_picked && (war || waw || is_branch[j])) ||
                                (is_branch[i] && is_compare[j]) ||
                                (is_compare[i] && is_branch[j]) ||
                                (is_memory[i] && is_memory[j]));
      end
    end

    assign ready[i] = entry_valid[i] && !(|blocked[i]);
  end

endmodule

//--- rtl/pipe_steer.sv
`timescale 1ns/100ps

module pipe_steer import issue_pkg::*; (
  input  logic [iq_depth-1:0]      ready,
  input  pipe_e                    pipe [iq_depth],
  input  logic [iq_depth-1:0]      entry_valid,
  output logic                     pop0,
  output logic [iq_index_bits-1:0] pop_key0,
  output logic                     pop1,
  output logic [iq_index_bits-1:0] pop_key1,
  output logic                     swap
);

  logic [iq_depth-1:0] candidate;
  logic                pick1;
  logic                pair_hazard;
  pipe_e               pipe0;
  pipe_e               pipe1;

  ////////////////////////////////////////////////////////////
  // priority picks, lowest slot wins
  ////////////////////////////////////////////////////////////

  // oldest valid entry, ready or not.
  always_comb begin
    pop0     = 1'b0;
    pop_key0 = '0;
    for (int k = iq_depth - 1; k >= 0; k--) begin
      if (entry_valid[k]) begin
        pop0     = 1'b1;
        pop_key0 = iq_index_bits'(k);
      end
    end
  end

  always_comb begin
    candidate = ready;
    if (pop0) candidate[pop_key0] = 1'b0;
  end

  always_comb begin
    pick1    = 1'b0;
    pop_key1 = '0;
    for (int k = iq_depth - 1; k >= 0; k--) begin
      if (candidate[k]) begin
        pick1    = 1'b1;
        pop_key1 = iq_index_bits'(k);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pair check and lane order
  ////////////////////////////////////////////////////////////

  assign pipe0 = pipe[pop_key0];
  assign pipe1 = pipe[pop_key1];

  // one branch unit, one memory unit.
  assign pair_hazard = (pipe0 == pipe1) && (pipe0 != pipe_any);
  assign pop1        = pop0 && pick1 && !pair_hazard;

  assign swap = (pop0 && (pipe0 == pipe_memory)) ||
                (pop1 && (pipe1 == pipe_branch));  // branch work to lane 0.

endmodule

//--- rtl/issue_stage.sv
`timescale 1ns/100ps

module issue_stage import issue_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  push0,
  input  logic                  push1,
  input  logic [inst_width-1:0] instruction0,
  input  logic [inst_width-1:0] instruction1,
  input  logic [addr_width-1:0] pc0,
  input  logic [addr_width-1:0] pc1,
  input  logic [id_width-1:0]   id0,
  input  logic [id_width-1:0]   id1,

  output logic                  stall,
  output logic [free_bits-1:0]  free,
  output logic                  issue_valid0,
  output logic                  issue_valid1,
  output logic [inst_width-1:0] issue_instruction0,
  output logic [inst_width-1:0] issue_instruction1,
  output logic [addr_width-1:0] issue_pc0,
  output logic [addr_width-1:0] issue_pc1,
  output logic [id_width-1:0]   issue_id0,
  output logic [id_width-1:0]   issue_id1
);

  logic [inst_width-1:0]    entry_instruction [iq_depth];
  logic [addr_width-1:0]    entry_pc          [iq_depth];
  logic [id_width-1:0]      entry_id          [iq_depth];
  logic [iq_depth-1:0]      entry_valid;
  opcode_e                  opcode [iq_depth];
  pipe_e                    pipe   [iq_depth];
  logic [reg_bits-1:0]      src0   [iq_depth];
  logic [reg_bits-1:0]      src1   [iq_depth];
  logic [reg_bits-1:0]      dest   [iq_depth];
  logic [iq_depth-1:0]      src0_valid, src1_valid, dest_valid;
  logic [iq_depth-1:0]      ready;
  logic                     pop0, pop1, swap;
  logic [iq_index_bits-1:0] pop_key0, pop_key1;
  logic                     push0_ok, push1_ok;
  logic                     lane_pop0, lane_pop1;
  logic [iq_index_bits-1:0] lane_key0, lane_key1;

  assign stall    = (free < free_bits'(2));
  assign push0_ok = push0 && !stall;
  assign push1_ok = push1 && push0 && !stall;  // push1 never alone.

  issue_queue i_issue_queue (
    .clk(clk), .reset(reset), .flush(flush),
    .push0(push0_ok), .push1(push1_ok),
    .instruction0(instruction0), .instruction1(instruction1),
    .pc0(pc0), .pc1(pc1), .id0(id0), .id1(id1),
    .pop0(pop0), .pop1(pop1), .pop_key0(pop_key0), .pop_key1(pop_key1),
    .entry_instruction(entry_instruction), .entry_pc(entry_pc), .entry_id(entry_id),
    .entry_valid(entry_valid), .free(free)
  );

  for (genvar i = 0; i < iq_depth; i++) begin : g_decode
    assign opcode[i] = opcode_e'(entry_instruction[i][opcode_lsb +: opcode_bits]);

    reg_decode i_reg_decode (
      .instruction(entry_instruction[i]),
      .src0(src0[i]), .src1(src1[i]), .dest(dest[i]),
      .src0_valid(src0_valid[i]), .src1_valid(src1_valid[i]),
      .dest_valid(dest_valid[i]), .pipe(pipe[i])
    );
  end

  order_hazard i_order_hazard (
    .opcode(opcode), .pipe(pipe), .src0(src0), .src1(src1), .dest(dest),
    .src0_valid(src0_valid), .src1_valid(src1_valid), .dest_valid(dest_valid),
    .entry_valid(entry_valid), .pop0(pop0), .pop_key0(pop_key0), .ready(ready)
  );

  pipe_steer i_pipe_steer (
    .ready(ready), .pipe(pipe), .entry_valid(entry_valid),
    .pop0(pop0), .pop_key0(pop_key0), .pop1(pop1), .pop_key1(pop_key1), .swap(swap)
  );

  ////////////////////////////////////////////////////////////
  // lane outputs
  ////////////////////////////////////////////////////////////

  assign lane_pop0 = swap ? pop1 : pop0;
  assign lane_pop1 = swap ? pop0 : pop1;
  assign lane_key0 = swap ? pop_key1 : pop_key0;
  assign lane_key1 = swap ? pop_key0 : pop_key1;

  assign issue_valid0       = lane_pop0 && !flush;
  assign issue_valid1       = lane_pop1 && !flush;
  assign issue_instruction0 = issue_valid0 ? entry_instruction[lane_key0] : '0;
  assign issue_instruction1 = issue_valid1 ? entry_instruction[lane_key1] : '0;
  assign issue_pc0          = issue_valid0 ? entry_pc[lane_key0] : '0;
  assign issue_pc1          = issue_valid1 ? entry_pc[lane_key1] : '0;
  assign issue_id0          = issue_valid0 ? entry_id[lane_key0] : '0;
  assign issue_id1          = issue_valid1 ? entry_id[lane_key1] : '0;

endmodule

//--- test/issue_checker.sv
`timescale 1ns/100ps

module issue_checker import issue_pkg::*; (
  input logic                  clk,
  input logic                  reset,
  input logic                  flush,
  input logic                  stall,
  input logic [free_bits-1:0]  free,
  input logic                  issue_valid0,
  input logic                  issue_valid1,
  input logic [inst_width-1:0] issue_instruction0,
  input logic [inst_width-1:0] issue_instruction1
);

  function automatic logic is_mem(logic [inst_width-1:0] ins);
    return ins[inst_width-1 -: 2] == grp_memory;
  endfunction

  function automatic logic is_br(logic [inst_width-1:0] ins);
    logic [opcode_bits-1:0] op;
    op = ins[opcode_lsb +: opcode_bits];
    return (op[opcode_bits-1 -: 2] == grp_branch) || op == op_cmp || op == op_test ||
           op == op_cmpi || op == op_testi;
  endfunction

  a_lane0_mem: assert property (@(posedge clk) disable iff (reset)
    (issue_valid0 && issue_valid1) |-> !is_mem(issue_instruction0))
    else $error("memory work on lane 0 beside a valid lane 1");

  a_two_br: assert property (@(posedge clk) disable iff (reset)
    !(issue_valid0 && issue_valid1 && is_br(issue_instruction0) && is_br(issue_instruction1)))
    else $error("two branch-class instructions issued together");

  // a stalled cycle only pops, so free cannot drop.
  a_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> (free >= $past(free)))
    else $error("push accepted while stalled");

  a_flush: assert property (@(posedge clk) disable iff (reset)
    flush |=> (free == free_bits'(iq_depth)))
    else $error("queue not empty after flush");

endmodule

//--- test/issue_monitor.sv
`timescale 1ns/100ps

module issue_monitor import issue_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  push0,
  input  logic                  push1,
  input  logic [inst_width-1:0] instruction0,
  input  logic [inst_width-1:0] instruction1,
  input  logic [addr_width-1:0] pc0,
  input  logic [addr_width-1:0] pc1,
  input  logic [id_width-1:0]   id0,
  input  logic [id_width-1:0]   id1,
  input  logic                  stall,
  input  logic [free_bits-1:0]  free,
  input  logic                  issue_valid0,
  input  logic                  issue_valid1,
  input  logic [inst_width-1:0] issue_instruction0,
  input  logic [inst_width-1:0] issue_instruction1,
  input  logic [addr_width-1:0] issue_pc0,
  input  logic [addr_width-1:0] issue_pc1,
  input  logic [id_width-1:0]   issue_id0,
  input  logic [id_width-1:0]   issue_id1,
  input  int                    test_id,
  input  logic                  test_done,
  output int                    error_total,
  output int                    tests_run
);

  logic [inst_width-1:0] m_instr [iq_depth];
  logic [addr_width-1:0] m_pc    [iq_depth];
  logic [id_width-1:0]   m_id    [iq_depth];
  int                    m_count;
  bit                    pending [1 << id_width];  // pushed, not yet issued.
  int                    test_errors;
  int                    test_checks;

  ////////////////////////////////////////////////////////////
  // decode rules
  ////////////////////////////////////////////////////////////

  function automatic logic [1:0] group_of(logic [inst_width-1:0] ins);
    return ins[inst_width-1 -: 2];
  endfunction

  function automatic bit is_compare(logic [inst_width-1:0] ins);
    logic [opcode_bits-1:0] op;
    op = ins[opcode_lsb +: opcode_bits];
    return op == op_cmp || op == op_test || op == op_cmpi || op == op_testi;
  endfunction

  function automatic pipe_e pipe_of(logic [inst_width-1:0] ins);
    if (group_of(ins) == 2'b10) return pipe_memory;
    if (group_of(ins) == 2'b11 || is_compare(ins)) return pipe_branch;
    return pipe_any;
  endfunction

  function automatic bit has_dest(logic [inst_width-1:0] ins);
    case (group_of(ins))
      2'b00:   return ins[opcode_lsb +: opcode_bits] != op_nop;
      2'b01:   return 1'b1;
      2'b10:   return ins[opcode_lsb +: opcode_bits] == op_lw;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [reg_bits-1:0] dest_reg(logic [inst_width-1:0] ins);
    return (group_of(ins) == 2'b00) ? ins[rd_lsb +: reg_bits] : ins[rt_lsb +: reg_bits];
  endfunction

  function automatic bit reads_reg(logic [inst_width-1:0] ins, logic [reg_bits-1:0] r);
    logic [reg_bits-1:0] rs;
    logic [reg_bits-1:0] rt;
    rs = ins[rs_lsb +: reg_bits];
    rt = ins[rt_lsb +: reg_bits];
    case (group_of(ins))
      2'b00:   return ins[opcode_lsb +: opcode_bits] != op_nop && (r == rs || r == rt);
      2'b01:   return r == rs;
      2'b10:   return (r == rs) || (ins[opcode_lsb +: opcode_bits] == op_sw && r == rt);
      default: return 1'b0;
    endcase
  endfunction

  // old entry holds back young entry.
  function automatic bit blocks(logic [inst_width-1:0] young, logic [inst_width-1:0] old,
                                bit old_picked);
    bit raw, war, waw, br_y, br_o, mem_y, mem_o;
    raw   = has_dest(old) && reads_reg(young, dest_reg(old));
    war   = has_dest(young) && reads_reg(old, dest_reg(young));
    waw   = has_dest(young) && has_dest(old) && dest_reg(young) == dest_reg(old);
    br_y  = group_of(young) == 2'b11;
    br_o  = group_of(old) == 2'b11;
    mem_y = group_of(young) == 2'b10;
    mem_o = group_of(old) == 2'b10;
    return raw || (!old_picked && (war || waw || br_o)) || (br_y && is_compare(old)) ||
           (is_compare(young) && br_o) || (mem_y && mem_o);
  endfunction

  function automatic string test_name(int n);
    case (n)
      1:       return "reset_flush";
      2:       return "alu_pairs";
      3:       return "raw_hold";
      4:       return "mem_branch_pairs";
      5:       return "steering";
      6:       return "random_mixed";
      default: return "idle";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic report(input string msg);
    error_total++;
    test_errors++;
    $display("%s", msg);
  endtask

  task automatic check_value(input string field, input logic [31:0] exp, input logic [31:0] act);
    test_checks++;
    if (exp !== act)
      report($sformatf("[ERROR] %s: %s expected %0h actual %0h",
                       test_name(test_id), field, exp, act));
  endtask

  task automatic check_lane(input int lane, input int slot, input logic v,
                            input logic [inst_width-1:0] ins, input logic [addr_width-1:0] pc,
                            input logic [id_width-1:0] id);
    check_value($sformatf("lane%0d valid", lane), (slot >= 0), v);
    check_value($sformatf("lane%0d instruction", lane), (slot >= 0) ? m_instr[slot] : '0, ins);
    check_value($sformatf("lane%0d pc", lane), (slot >= 0) ? m_pc[slot] : '0, pc);
    check_value($sformatf("lane%0d id", lane), (slot >= 0) ? m_id[slot] : '0, id);
    if (slot >= 0) begin
      if (!pending[m_id[slot]])
        report($sformatf("%s: id %0d issued without a matching push",
                         test_name(test_id), m_id[slot]));
      pending[m_id[slot]] = 1'b0;
    end
  endtask

  initial begin
    error_total = 0;
    tests_run   = 0;
    test_errors = 0;
    test_checks = 0;
    m_count     = 0;
  end

  always @(negedge clk) begin : model
    logic [inst_width-1:0] n_instr [iq_depth];
    logic [addr_width-1:0] n_pc    [iq_depth];
    logic [id_width-1:0]   n_id    [iq_depth];
    int  k1, n, lane0, lane1, slot_a;
    bit  rdy, p1, swap, full;

    if (reset) begin
      m_count = 0;
      foreach (pending[i]) pending[i] = 1'b0;
    end else begin
      k1 = -1;
      for (int k = 1; k < m_count; k++) begin
        rdy = 1'b1;
        for (int j = 0; j < k; j++)
          if (blocks(m_instr[k], m_instr[j], j == 0)) rdy = 1'b0;
        if (rdy && k1 < 0) k1 = k;
      end
      p1 = (k1 >= 0);
      if (p1 && pipe_of(m_instr[0]) == pipe_of(m_instr[k1]) && pipe_of(m_instr[0]) != pipe_any)
        p1 = 1'b0;  // one unit per class.
      slot_a = (m_count > 0) ? 0 : -1;
      swap = (m_count > 0) && (pipe_of(m_instr[0]) == pipe_memory ||
                               (p1 && pipe_of(m_instr[k1]) == pipe_branch));
      lane0 = swap ? (p1 ? k1 : -1) : slot_a;
      lane1 = swap ? slot_a : (p1 ? k1 : -1);
      if (flush) begin
        lane0 = -1;
        lane1 = -1;
      end
      check_lane(0, lane0, issue_valid0, issue_instruction0, issue_pc0, issue_id0);
      check_lane(1, lane1, issue_valid1, issue_instruction1, issue_pc1, issue_id1);
      check_value("free", iq_depth - m_count, free);
      full = (m_count > iq_depth - 2);
      check_value("stall", full, stall);

      if (flush) begin
        m_count = 0;
        foreach (pending[i]) pending[i] = 1'b0;
      end else begin
        n = 0;
        for (int k = 1; k < m_count; k++) begin
          if (!(p1 && k == k1)) begin
            n_instr[n] = m_instr[k];
            n_pc[n]    = m_pc[k];
            n_id[n]    = m_id[k];
            n++;
          end
        end
        if (push0 && !full) begin
          n_instr[n] = instruction0;
          n_pc[n]    = pc0;
          n_id[n]    = id0;
          pending[id0] = 1'b1;
          n++;
          if (push1) begin
            n_instr[n] = instruction1;
            n_pc[n]    = pc1;
            n_id[n]    = id1;
            pending[id1] = 1'b1;
            n++;
          end
        end
        for (int k = 0; k < n; k++) begin
          m_instr[k] = n_instr[k];
          m_pc[k]    = n_pc[k];
          m_id[k]    = n_id[k];
        end
        m_count = n;
      end
    end

    if (test_done) begin
      foreach (pending[i]) begin
        if (pending[i])
          report($sformatf("%s: id %0d was pushed but never issued", test_name(test_id), i));
        pending[i] = 1'b0;
      end
      tests_run++;
      $display("test %s: %0d checks, %0d errors", test_name(test_id), test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

//--- test/issue_stage_tb.sv
`timescale 1ns/100ps

module issue_stage_tb import issue_pkg::*; ();

  localparam int reset_cycles  = 10;
  localparam int random_cycles = 400;
  // per-test budgets with the drain included.
  localparam int budget_total  = 60 + 40 + 40 + 40 + 40 + (random_cycles + 20);
  localparam int cycle_limit   = 2 * (reset_cycles + budget_total);

  logic                  clk, reset, flush, push0, push1;
  logic [inst_width-1:0] instruction0, instruction1;
  logic [addr_width-1:0] pc0, pc1;
  logic [id_width-1:0]   id0, id1;
  logic                  stall, issue_valid0, issue_valid1;
  logic [free_bits-1:0]  free;
  logic [inst_width-1:0] issue_instruction0, issue_instruction1;
  logic [addr_width-1:0] issue_pc0, issue_pc1;
  logic [id_width-1:0]   issue_id0, issue_id1;

  int                    seed;
  int                    cycles;
  int                    test_id;
  logic                  test_done;
  logic [id_width-1:0]   next_id;
  int                    error_total;
  int                    tests_run;

  issue_stage i_issue_stage (.*);

  issue_monitor i_issue_monitor (.*);

  bind issue_stage issue_checker i_issue_checker (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [inst_width-1:0] make_instr(opcode_e op, int rs, int rt, int rd);
    return {op, 5'(rs), 5'(rt), 5'(rd), 11'd0};
  endfunction

  function automatic logic [inst_width-1:0] rand_instr();
    opcode_e ops [14];
    int      k;
    ops = '{op_nop, op_add, op_sub, op_cmp, op_test, op_addi, op_subi, op_cmpi,
            op_testi, op_lw, op_sw, op_jmp, op_je, op_jo};
    k = $unsigned($random(seed)) % 14;
    return make_instr(ops[k], $unsigned($random(seed)) % 8, $unsigned($random(seed)) % 8,
                      $unsigned($random(seed)) % 8);  // registers 0 to 7 only.
  endfunction

  // retries while the stage stalls.
  task automatic push_pair(input logic [inst_width-1:0] a, input logic [inst_width-1:0] b,
                           input bit two);
    bit accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      push0        <= 1'b1;
      push1        <= two;
      instruction0 <= a;
      instruction1 <= b;
      id0          <= next_id;
      id1          <= next_id + 1'b1;
      pc0          <= addr_width'(next_id) << 2;
      pc1          <= addr_width'(next_id + 1'b1) << 2;
      @(negedge clk);
      accepted = !stall;
    end
    next_id = next_id + id_width'(two ? 2 : 1);
  endtask

  task automatic drain();
    @(posedge clk);
    push0 <= 1'b0;
    push1 <= 1'b0;
    flush <= 1'b0;
    @(negedge clk);
    while (free != free_bits'(iq_depth)) @(negedge clk);
  endtask

  task automatic end_test();
    drain();
    @(posedge clk);
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  task automatic random_traffic();
    int n;
    bit f;
    for (int c = 0; c < random_cycles; c++) begin
      f = ($unsigned($random(seed)) % 32) == 0;
      n = $unsigned($random(seed)) % 3;
      @(posedge clk);
      flush        <= f;
      push0        <= (n > 0);
      push1        <= (n > 1);
      instruction0 <= rand_instr();
      instruction1 <= rand_instr();
      id0          <= next_id;
      id1          <= next_id + 1'b1;
      pc0          <= addr_width'(next_id) << 2;
      pc1          <= addr_width'(next_id + 1'b1) << 2;
      @(negedge clk);
      if (n > 0 && !stall) next_id = next_id + id_width'(n);
    end
  endtask

  initial begin
    seed = 32'ha0d85f02;
    cycles = 0;
    next_id = '0;
    test_id = 0;
    test_done = 1'b0;
    reset = 1'b1;
    flush = 1'b0;
    push0 = 1'b0;
    push1 = 1'b0;
    instruction0 = '0;
    instruction1 = '0;
    pc0 = '0;
    pc1 = '0;
    id0 = '0;
    id1 = '0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    test_id = 1;
    repeat (7) push_pair(make_instr(op_add, 1, 1, 1), make_instr(op_add, 1, 1, 1), 1'b1);
    @(posedge clk);
    push0 <= 1'b0;
    push1 <= 1'b0;
    flush <= 1'b1;  // queue still full of the chain.
    end_test();

    test_id = 2;
    for (int k = 0; k < 8; k++)
      push_pair(make_instr(op_add, 0, 1, 2 + k % 3),
                make_instr(op_subi, 5, 6 + k % 2, 0), 1'b1);
    end_test();

    test_id = 3;
    for (int k = 0; k < 4; k++) begin
      push_pair(make_instr(op_add, 0, 1, 4), make_instr(op_add, 4, 4, 5), 1'b1);
      push_pair(make_instr(op_addi, 5, 6, 0), make_instr(op_sw, 6, 4, 0), 1'b1);
    end
    end_test();

    test_id = 4;
    push_pair(make_instr(op_lw, 0, 2, 0), make_instr(op_sw, 1, 3, 0), 1'b1);
    push_pair(make_instr(op_je, 0, 0, 0), make_instr(op_jo, 0, 0, 0), 1'b1);
    push_pair(make_instr(op_cmp, 1, 2, 0), make_instr(op_jmp, 0, 0, 0), 1'b1);
    push_pair(make_instr(op_testi, 3, 0, 0), make_instr(op_cmpi, 4, 0, 0), 1'b1);
    push_pair(make_instr(op_lw, 5, 6, 0), make_instr(op_lw, 7, 1, 0), 1'b1);
    end_test();

    test_id = 5;
    push_pair(make_instr(op_lw, 0, 2, 0), make_instr(op_add, 3, 4, 5), 1'b1);
    push_pair(make_instr(op_add, 1, 1, 6), make_instr(op_je, 0, 0, 0), 1'b1);
    push_pair(make_instr(op_sw, 0, 1, 0), make_instr(op_cmpi, 7, 0, 0), 1'b1);
    drain();
    push_pair(make_instr(op_lw, 0, 3, 0), '0, 1'b0);
    drain();
    push_pair(make_instr(op_je, 0, 0, 0), '0, 1'b0);
    drain();
    push_pair(make_instr(op_add, 1, 2, 3), '0, 1'b0);
    end_test();

    test_id = 6;
    random_traffic();
    end_test();

    $display("tests run: %0d, errors: %0d", tests_run, error_total);
    if (error_total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/issue_pkg.sv
rtl/issue_queue.sv
rtl/reg_decode.sv
rtl/order_hazard.sv
rtl/pipe_steer.sv
rtl/issue_stage.sv
test/issue_checker.sv
test/issue_monitor.sv
test/issue_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
